// File: Bender.yml
package:
  name: apb_sub

sources:
  - files:
      - design/apb_sub_pkg.sv
      - design/ahb_apb_bridge.sv
      - design/apb_slot_decoder.sv
      - design/irq_wake_ctrl.sv
      - design/apb_sub_top.sv
  - target: test
    files:
      - dv/apb_sub_chk.sv
      - dv/apb_sub_tb.sv

// File: design/ahb_apb_bridge.sv
// AHB-lite slave to APB bridge
// Five-state FSM: idle, APB setup, APB access, two-cycle error
// Address and direction capture on accept, write data latch in setup
// Read data register and AHB response generation

`default_nettype none

module ahb_apb_bridge (
  input  logic                                i_hclk,
  input  logic                                i_arst_n,
  // AHB-lite slave side
  input  logic                                i_hsel,
  input  logic [apb_sub_pkg::ADDR_W-1:0]      i_haddr,
  input  logic [1:0]                          i_htrans,
  input  logic                                i_hwrite,
  input  logic [apb_sub_pkg::DATA_W-1:0]      i_hwdata,
  input  logic                                i_hready_in,
  output logic [apb_sub_pkg::DATA_W-1:0]      o_hrdata,
  output logic                                o_hready,
  output logic [1:0]                          o_hresp,
  // APB master side
  output apb_sub_pkg::apb_req_t               o_apb_req,
  output logic                                o_psel_any,
  input  logic                                i_hit,      // From decoder
  input  apb_sub_pkg::apb_rsp_t               i_apb_rsp
);

  typedef enum logic [2:0] {
    ST_IDLE,
    ST_SETUP,
    ST_ACCESS,
    ST_ERR1,     // ERROR, hready low
    ST_ERR2      // ERROR, hready high
  } state_t;

  state_t                           state_q;
  state_t                           state_d;
  logic                             bus_free;    // hready high this cycle
  logic                             accept;
  logic [apb_sub_pkg::ADDR_W-1:0]   addr_q;
  logic                             write_q;
  logic [apb_sub_pkg::DATA_W-1:0]   wdata_q;
  logic [apb_sub_pkg::DATA_W-1:0]   rdata_q;

  // --------------------------------------------------
  // Accept and next state
  // --------------------------------------------------
  assign bus_free = (state_q == ST_IDLE) || (state_q == ST_ERR2);
  assign accept   = bus_free && i_hsel && i_hready_in &&
                    ((i_htrans == apb_sub_pkg::HTRANS_NONSEQ) ||
                     (i_htrans == apb_sub_pkg::HTRANS_SEQ));

  always_comb begin
    state_d = state_q;
    case (state_q)
      ST_IDLE, ST_ERR2: begin
        // Decoder sees the incoming address while the bus is free
        if (accept) begin
          state_d = i_hit ? ST_SETUP : ST_ERR1;
        end else begin
          state_d = ST_IDLE;
        end
      end
      ST_SETUP:  state_d = ST_ACCESS;              // Exactly one setup cycle
      ST_ACCESS: begin
        if (i_apb_rsp.pready) begin
          state_d = ST_IDLE;                       // Completion cycle follows
        end
      end
      ST_ERR1:   state_d = ST_ERR2;
      default:   state_d = ST_IDLE;
    endcase
  end

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      state_q <= ST_IDLE;
      write_q <= 1'b0;
    end else begin
      state_q <= state_d;
      if (accept) begin
        write_q <= i_hwrite;
      end
    end
  end

  // --------------------------------------------------
  // Payload registers
  // --------------------------------------------------
  always_ff @(posedge i_hclk) begin
    if (accept) begin
      addr_q <= i_haddr;
    end
    if ((state_q == ST_SETUP) && write_q) begin
      wdata_q <= i_hwdata;                         // AHB data phase
    end
    if ((state_q == ST_ACCESS) && i_apb_rsp.pready) begin
      rdata_q <= i_apb_rsp.prdata;
    end
  end

  // --------------------------------------------------
  // APB request
  // --------------------------------------------------
  always_comb begin
    o_apb_req.paddr.raw = bus_free ? i_haddr : addr_q;
    o_apb_req.pwdata    = (state_q == ST_SETUP) ? i_hwdata : wdata_q;
    o_apb_req.pwrite    = write_q;
    o_apb_req.penable   = (state_q == ST_ACCESS);
    o_apb_req.pstrb     = '0;                      // Decoder fills the lanes
  end

  assign o_psel_any = (state_q == ST_SETUP) || (state_q == ST_ACCESS);

  // AHB response
  assign o_hready = bus_free;
  assign o_hresp  = ((state_q == ST_ERR1) || (state_q == ST_ERR2)) ?
                    apb_sub_pkg::HRESP_ERROR : apb_sub_pkg::HRESP_OKAY;
  assign o_hrdata = rdata_q;

endmodule

`default_nettype wire

// File: design/apb_slot_decoder.sv
// APB slot decoder
// Region and slot decode into a one-hot select and a hit flag
// Byte-lane strobes for the UART slots
// Read data and ready multiplexing back to the bridge

`default_nettype none

module apb_slot_decoder (
  input  apb_sub_pkg::apb_req_t                             i_apb_req,
  input  logic                                              i_psel_any,
  output apb_sub_pkg::apb_req_t                             o_apb_req,
  output apb_sub_pkg::slot_sel_t                            o_psel,
  output logic                                              o_hit,
  input  apb_sub_pkg::apb_rsp_t [apb_sub_pkg::NUM_SLOTS-1:0] i_apb_rsp,
  input  apb_sub_pkg::apb_rsp_t                             i_pmc_rsp,
  output apb_sub_pkg::apb_rsp_t                             o_apb_rsp
);

  logic                             region_ok;
  logic                             slot_ok;
  apb_sub_pkg::slot_sel_t           slot_hot;    // Decoded slot, not yet gated
  logic                             byte_slot;
  logic [apb_sub_pkg::STRB_W-1:0]   lane_strb;

  // --------------------------------------------------
  // Decode
  // --------------------------------------------------
  assign region_ok = (i_apb_req.paddr.f.region == apb_sub_pkg::SLOT_REGION);
  assign slot_ok   = (i_apb_req.paddr.f.slot < apb_sub_pkg::NUM_SLOTS);  // 9..15 unmapped
  assign o_hit     = region_ok && slot_ok;

  always_comb begin
    for (int i = 0; i < apb_sub_pkg::NUM_SLOTS; i++) begin
      slot_hot[i] = o_hit && (i_apb_req.paddr.f.slot == i);
    end
  end

  assign o_psel = slot_hot & {apb_sub_pkg::NUM_SLOTS{i_psel_any}};

  // Byte lanes, little-endian
  assign byte_slot = |(slot_hot & apb_sub_pkg::BYTE_SLOTS);

  always_comb begin
    lane_strb = '0;
    lane_strb[i_apb_req.paddr.f.offset[1:0]] = 1'b1;
  end

  always_comb begin
    o_apb_req       = i_apb_req;
    o_apb_req.pstrb = byte_slot ? lane_strb : '1;  // Word slots take all lanes
  end

  // --------------------------------------------------
  // Response mux
  // --------------------------------------------------
  always_comb begin
    o_apb_rsp.prdata = '0;
    o_apb_rsp.pready = 1'b1;                       // Nothing selected
    for (int i = 0; i < apb_sub_pkg::NUM_SLOTS; i++) begin
      if (slot_hot[i]) begin
        o_apb_rsp = (i == apb_sub_pkg::SLOT_PMC) ? i_pmc_rsp : i_apb_rsp[i];
      end
    end
  end

endmodule

`default_nettype wire

// File: design/apb_sub_pkg.sv
// Shared definitions for the APB subsystem fabric
// Bus widths and the peripheral slot map
// Register offsets of the interrupt and wake-up slot
// AHB transfer and response codes
// Address union, APB request and response structs, interrupt sources

`default_nettype none

package apb_sub_pkg;

  // --------------------------------------------------
  // Widths
  // --------------------------------------------------
  localparam int ADDR_W   = 32;
  localparam int DATA_W   = 32;
  localparam int STRB_W   = DATA_W / 8;                  // One strobe per byte lane
  localparam int SLOT_W   = 4;                           // Address bits 19:16
  localparam int OFFS_W   = 16;                          // 64 KB per slot
  localparam int REGION_W = ADDR_W - SLOT_W - OFFS_W;    // Address bits 31:20

  // --------------------------------------------------
  // Slot map
  // --------------------------------------------------
  localparam int NUM_SLOTS = 9;                          // 0x0080_0000 .. 0x0088_FFFF
  localparam int SLOT_PMC  = 6;                          // Served internally
  localparam logic [REGION_W-1:0]  SLOT_REGION = 12'h008;
  localparam logic [NUM_SLOTS-1:0] BYTE_SLOTS  = 9'b1_0000_0010;  // UART1, UART0

  // Slot 6 register offsets
  localparam logic [OFFS_W-1:0] REG_CTRL   = 16'h0000;   // Bit 0 hibernate
  localparam logic [OFFS_W-1:0] REG_MASK   = 16'h0004;   // Per-source enable
  localparam logic [OFFS_W-1:0] REG_STATUS = 16'h0008;   // Registered raw sources, RO

  // --------------------------------------------------
  // AHB codes
  // --------------------------------------------------
  localparam logic [1:0] HTRANS_NONSEQ = 2'b10;
  localparam logic [1:0] HTRANS_SEQ    = 2'b11;
  localparam logic [1:0] HRESP_OKAY    = 2'b00;
  localparam logic [1:0] HRESP_ERROR   = 2'b01;

  // One-hot peripheral select
  typedef logic [NUM_SLOTS-1:0] slot_sel_t;

  // One address word, raw or split into region, slot and offset
  typedef union packed {
    logic [ADDR_W-1:0] raw;
    struct packed {
      logic [REGION_W-1:0] region;
      logic [SLOT_W-1:0]   slot;
      logic [OFFS_W-1:0]   offset;
    } f;
  } apb_addr_u;

  // Request shared by all slots, psel travels beside it
  typedef struct packed {
    apb_addr_u         paddr;
    logic [DATA_W-1:0] pwdata;
    logic              pwrite;
    logic              penable;
    logic [STRB_W-1:0] pstrb;
  } apb_req_t;

  typedef struct packed {
    logic [DATA_W-1:0] prdata;
    logic              pready;
  } apb_rsp_t;

  // Peripheral interrupt sources
  typedef struct packed {
    logic       dma;
    logic       spi;
    logic       uart1;
    logic       uart0;
    logic       gpio;
    logic [2:0] ttc;      // Three timer channels
    logic [3:0] mac;      // Four Ethernet MACs
  } irq_src_t;

  localparam int NUM_IRQ = $bits(irq_src_t);

endpackage

`default_nettype wire

// File: design/apb_sub_top.sv
// APB subsystem fabric top level
// AHB-lite to APB bridge, slot decoder, interrupt and wake-up controller
// Eight external APB slots brought out as request and response ports

`default_nettype none

module apb_sub_top (
  input  logic                                              i_hclk,
  input  logic                                              i_arst_n,
  // AHB-lite slave
  input  logic                                              i_hsel,
  input  logic [apb_sub_pkg::ADDR_W-1:0]                    i_haddr,
  input  logic [1:0]                                        i_htrans,
  input  logic                                              i_hwrite,
  input  logic [apb_sub_pkg::DATA_W-1:0]                    i_hwdata,
  input  logic                                              i_hready_in,
  output logic [apb_sub_pkg::DATA_W-1:0]                    o_hrdata,
  output logic                                              o_hready,
  output logic [1:0]                                        o_hresp,
  // External APB slots, entry 6 of the response unused
  output apb_sub_pkg::apb_req_t                             o_apb_req,
  output apb_sub_pkg::slot_sel_t                            o_psel,
  input  apb_sub_pkg::apb_rsp_t [apb_sub_pkg::NUM_SLOTS-1:0] i_apb_rsp,
  // Interrupts
  input  apb_sub_pkg::irq_src_t                             i_irq_src,
  output apb_sub_pkg::irq_src_t                             o_irq,
  output logic                                              o_wake
);

  apb_sub_pkg::apb_req_t  bridge_req;   // Before strobe fill
  apb_sub_pkg::apb_rsp_t  sel_rsp;      // Selected slot back to bridge
  apb_sub_pkg::apb_rsp_t  pmc_rsp;
  logic                   psel_any;
  logic                   slot_hit;

  ahb_apb_bridge u_bridge (
    .i_hclk      (i_hclk),
    .i_arst_n    (i_arst_n),
    .i_hsel      (i_hsel),
    .i_haddr     (i_haddr),
    .i_htrans    (i_htrans),
    .i_hwrite    (i_hwrite),
    .i_hwdata    (i_hwdata),
    .i_hready_in (i_hready_in),
    .o_hrdata    (o_hrdata),
    .o_hready    (o_hready),
    .o_hresp     (o_hresp),
    .o_apb_req   (bridge_req),
    .o_psel_any  (psel_any),
    .i_hit       (slot_hit),
    .i_apb_rsp   (sel_rsp)
  );

  apb_slot_decoder u_decoder (
    .i_apb_req   (bridge_req),
    .i_psel_any  (psel_any),
    .o_apb_req   (o_apb_req),
    .o_psel      (o_psel),
    .o_hit       (slot_hit),
    .i_apb_rsp   (i_apb_rsp),
    .i_pmc_rsp   (pmc_rsp),
    .o_apb_rsp   (sel_rsp)
  );

  // Slot 6 served on chip
  irq_wake_ctrl u_irq_wake (
    .i_hclk      (i_hclk),
    .i_arst_n    (i_arst_n),
    .i_apb_req   (o_apb_req),
    .i_psel      (o_psel[apb_sub_pkg::SLOT_PMC]),
    .i_irq_src   (i_irq_src),
    .o_pmc_rsp   (pmc_rsp),
    .o_irq       (o_irq),
    .o_wake      (o_wake)
  );

endmodule

`default_nettype wire

// File: design/irq_wake_ctrl.sv
// Interrupt and wake-up controller on slot 6
// CTRL, MASK and STATUS registers on APB
// Source registering and mask gating
// Wake condition and one-cycle wake pulse

`default_nettype none

module irq_wake_ctrl (
  input  logic                   i_hclk,
  input  logic                   i_arst_n,
  input  apb_sub_pkg::apb_req_t  i_apb_req,
  input  logic                   i_psel,
  input  apb_sub_pkg::irq_src_t  i_irq_src,
  output apb_sub_pkg::apb_rsp_t  o_pmc_rsp,
  output apb_sub_pkg::irq_src_t  o_irq,
  output logic                   o_wake
);

  apb_sub_pkg::irq_src_t               src_q;        // Registered raw sources
  logic [apb_sub_pkg::NUM_IRQ-1:0]     mask_q;
  logic                                hib_q;        // CTRL bit 0
  logic                                wr_en;
  logic [apb_sub_pkg::OFFS_W-1:0]      offset;
  logic [apb_sub_pkg::DATA_W-1:0]      rdata;
  logic                                wake_cond;
  logic                                wake_cond_q;
  logic                                wake_q;

  assign offset = i_apb_req.paddr.f.offset;
  assign wr_en  = i_psel && i_apb_req.penable && i_apb_req.pwrite;  // Access cycle

  // --------------------------------------------------
  // Registers
  // --------------------------------------------------
  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      hib_q  <= 1'b0;
      mask_q <= '0;
    end else if (wr_en) begin
      case (offset)
        apb_sub_pkg::REG_CTRL: hib_q  <= i_apb_req.pwdata[0];
        apb_sub_pkg::REG_MASK: mask_q <= i_apb_req.pwdata[apb_sub_pkg::NUM_IRQ-1:0];
        default: ;                                 // STATUS is read-only
      endcase
    end
  end

  // Read mux, unknown offsets return zero
  always_comb begin
    rdata = '0;
    case (offset)
      apb_sub_pkg::REG_CTRL:   rdata[0] = hib_q;
      apb_sub_pkg::REG_MASK:   rdata[apb_sub_pkg::NUM_IRQ-1:0] = mask_q;
      apb_sub_pkg::REG_STATUS: rdata[apb_sub_pkg::NUM_IRQ-1:0] = src_q;
      default: ;
    endcase
  end

  assign o_pmc_rsp.prdata = rdata;
  assign o_pmc_rsp.pready = 1'b1;                  // Zero wait states

  // --------------------------------------------------
  // Interrupts and wake
  // --------------------------------------------------
  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      src_q <= '0;
    end else begin
      src_q <= i_irq_src;                          // One cycle of latency
    end
  end

  assign o_irq = apb_sub_pkg::irq_src_t'(src_q & mask_q);

  // Sleep: any enabled source, hibernate: GPIO only
  assign wake_cond = ((|o_irq) && !hib_q) || (hib_q && src_q.gpio);

  always_ff @(posedge i_hclk or negedge i_arst_n) begin
    if (!i_arst_n) begin
      wake_cond_q <= 1'b0;
      wake_q      <= 1'b0;
    end else begin
      wake_cond_q <= wake_cond;
      wake_q      <= wake_cond && !wake_cond_q;    // Rising edge only
    end
  end

  assign o_wake = wake_q;

endmodule

`default_nettype wire

// File: dv/apb_sub_chk.sv
// APB protocol checker for the AHB-lite to APB bridge
// Setup before access, stable address and direction, AHB stall during APB
// Bound to ahb_apb_bridge, failures counted in err_count

`default_nettype none

module apb_sub_chk (
  input  logic                               i_hclk,
  input  logic                               i_arst_n,
  input  logic                               i_psel,
  input  logic                               i_penable,
  input  logic [apb_sub_pkg::ADDR_W-1:0]     i_paddr,
  input  logic                               i_pwrite,
  input  logic                               i_hready
);

  int err_count = 0;   // Read by the testbench top

  // --------------------------------------------------
  // Phase order
  // --------------------------------------------------
  a_setup_first: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
    $rose(i_penable) |-> $past(i_psel) && !$past(i_psel, 2))
    else begin
      $error("penable rose without a single setup cycle");
      err_count++;
    end

  // Address and direction held for the whole transfer
  a_stable_req: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
    i_psel && $past(i_psel) |-> $stable(i_paddr) && $stable(i_pwrite))
    else begin
      $error("paddr or pwrite changed while psel held");
      err_count++;
    end

  a_ahb_stall: assert property (@(posedge i_hclk) disable iff (!i_arst_n)
    i_psel |-> !i_hready)
    else begin
      $error("hready high during an APB transfer");
      err_count++;
    end

endmodule

`default_nettype wire

// File: dv/apb_sub_tb.sv
// Testbench for the APB subsystem fabric
// Clock, reset, external APB slot models with slot-dependent wait states
// Directed tests: slot writes, slot reads, unmapped access, slot 6 registers,
// interrupt masking and wake
// Compare tasks, timeout and summary

`default_nettype none

module apb_sub_tb;

  logic                                              hclk;
  logic                                              arst_n;
  logic                                              hsel;
  logic [apb_sub_pkg::ADDR_W-1:0]                    haddr;
  logic [1:0]                                        htrans;
  logic                                              hwrite;
  logic [apb_sub_pkg::DATA_W-1:0]                    hwdata;
  logic                                              hready_in;
  logic [apb_sub_pkg::DATA_W-1:0]                    hrdata;
  logic                                              hready;
  logic [1:0]                                        hresp;
  apb_sub_pkg::apb_req_t                             apb_req;
  apb_sub_pkg::slot_sel_t                            psel;
  apb_sub_pkg::apb_rsp_t [apb_sub_pkg::NUM_SLOTS-1:0] apb_rsp;
  apb_sub_pkg::irq_src_t                             irq_src;
  apb_sub_pkg::irq_src_t                             irq;
  logic                                              wake;

  logic [31:0]                 lcg_state;
  int                          errors = 0;
  int                          checks = 0;
  int                          cycle_cnt = 0;
  logic [3:0]                  wait_cnt;     // Access cycles so far
  logic                        apb_done;
  int                          apb_cnt;      // Completed APB transfers
  int                          psel_cnt;     // Cycles with any psel
  int                          wake_cnt;     // o_wake pulses seen
  apb_sub_pkg::apb_req_t       log_req;      // Last completed request
  apb_sub_pkg::slot_sel_t      log_sel;

  apb_sub_top apb_sub_i (
    .i_hclk      (hclk),
    .i_arst_n    (arst_n),
    .i_hsel      (hsel),
    .i_haddr     (haddr),
    .i_htrans    (htrans),
    .i_hwrite    (hwrite),
    .i_hwdata    (hwdata),
    .i_hready_in (hready_in),
    .o_hrdata    (hrdata),
    .o_hready    (hready),
    .o_hresp     (hresp),
    .o_apb_req   (apb_req),
    .o_psel      (psel),
    .i_apb_rsp   (apb_rsp),
    .i_irq_src   (irq_src),
    .o_irq       (irq),
    .o_wake      (wake)
  );

  bind ahb_apb_bridge apb_sub_chk u_chk (
    .i_hclk    (i_hclk),
    .i_arst_n  (i_arst_n),
    .i_psel    (o_psel_any),
    .i_penable (o_apb_req.penable),
    .i_paddr   (o_apb_req.paddr.raw),
    .i_pwrite  (o_apb_req.pwrite),
    .i_hready  (o_hready)
  );

  initial begin
    hclk = 1'b0;
    forever #4 hclk = ~hclk;
  end

  // --------------------------------------------------
  // Slot models, slot s waits s cycles
  // --------------------------------------------------
  assign apb_done = apb_req.penable && (|psel) &&
                    (psel[apb_sub_pkg::SLOT_PMC] || (wait_cnt == apb_req.paddr.f.slot));

  always_comb begin
    for (int s = 0; s < apb_sub_pkg::NUM_SLOTS; s++) begin
      apb_rsp[s].pready = (wait_cnt == s);
      apb_rsp[s].prdata = {8'(s), 24'h0} ^ {16'h0, apb_req.paddr.f.offset};
    end
    apb_rsp[apb_sub_pkg::SLOT_PMC].pready = 1'b0;   // Entry ignored by DUT, would hang
    apb_rsp[apb_sub_pkg::SLOT_PMC].prdata = '1;
  end

  always_ff @(posedge hclk or negedge arst_n) begin
    if (!arst_n) begin
      wait_cnt <= '0;
      apb_cnt  <= 0;
      psel_cnt <= 0;
      wake_cnt <= 0;
      log_req  <= '0;
      log_sel  <= '0;
    end else begin
      wait_cnt <= (apb_req.penable && !apb_done) ? wait_cnt + 4'd1 : 4'd0;
      if (apb_done) begin
        apb_cnt <= apb_cnt + 1;
        log_req <= apb_req;
        log_sel <= psel;
      end
      if (|psel) psel_cnt <= psel_cnt + 1;
      if (wake) wake_cnt <= wake_cnt + 1;
    end
  end

  // Longest transfer is 11 cycles, about 50 transfers plus irq waits
  always @(posedge hclk) begin
    cycle_cnt <= cycle_cnt + 1;
    if (cycle_cnt >= 3000) begin
      $display("Timeout: run did not finish within 3000 cycles");
      $display("FAIL: see errors above");
      $finish;
    end
  end

  // --------------------------------------------------
  // Helpers
  // --------------------------------------------------
  function automatic logic [31:0] lcg_next();
    lcg_state = lcg_state * 32'd1664525 + 32'd1013904223;
    return lcg_state;
  endfunction

  function automatic logic [apb_sub_pkg::DATA_W-1:0] irq_word(apb_sub_pkg::irq_src_t v);
    return {{(apb_sub_pkg::DATA_W - apb_sub_pkg::NUM_IRQ){1'b0}}, v};
  endfunction

  task automatic wait_cycles(input int n);
    repeat (n) @(negedge hclk);
  endtask

  task automatic note_fail(input string tname, input string exp, input string act);
    errors++;
    $display("[FAIL] %s: expected %s, actual %s", tname, exp, act);
  endtask

  task automatic check_word(input string tname, input logic [apb_sub_pkg::DATA_W-1:0] exp,
                            input logic [apb_sub_pkg::DATA_W-1:0] act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%h", exp), $sformatf("%h", act));
  endtask

  task automatic check_resp(input string tname, input logic [1:0] exp, input logic [1:0] act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_sel(input string tname, input apb_sub_pkg::slot_sel_t exp,
                           input apb_sub_pkg::slot_sel_t act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_strb(input string tname, input logic [apb_sub_pkg::STRB_W-1:0] exp,
                            input logic [apb_sub_pkg::STRB_W-1:0] act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_irq(input string tname, input apb_sub_pkg::irq_src_t exp,
                           input apb_sub_pkg::irq_src_t act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_bit(input string tname, input logic exp, input logic act);
    checks++;
    if (act !== exp) note_fail(tname, $sformatf("%b", exp), $sformatf("%b", act));
  endtask

  task automatic check_count(input string tname, input int exp, input int act);
    checks++;
    if (act != exp) note_fail(tname, $sformatf("%0d", exp), $sformatf("%0d", act));
  endtask

  // One AHB transfer, lat counts cycles after the accept edge up to hready high
  task automatic ahb_xfer(input logic [31:0] addr, input logic write, input logic [31:0] wdata,
                          output logic [31:0] rdata, output logic [1:0] resp_early,
                          output logic [1:0] resp, output int lat);
    int n;
    n = 0;
    @(posedge hclk);
    hsel   <= 1'b1;
    haddr  <= addr;
    htrans <= apb_sub_pkg::HTRANS_NONSEQ;
    hwrite <= write;
    @(posedge hclk);                          // Accept edge
    hsel   <= 1'b0;
    htrans <= 2'b00;
    hwdata <= wdata;                          // Data phase
    do begin
      @(negedge hclk);
      n++;
      if (n == 1) resp_early = hresp;
    end while (!hready);
    rdata = hrdata;
    resp  = hresp;
    lat   = n;
  endtask

  function automatic logic [31:0] pmc_addr(input logic [15:0] offset);
    return {apb_sub_pkg::SLOT_REGION, 4'(apb_sub_pkg::SLOT_PMC), offset};
  endfunction

  task automatic reg_write(input string tname, input logic [15:0] offset, input logic [31:0] d);
    logic [31:0] rdata;
    logic [1:0]  re;
    logic [1:0]  r;
    int          lat;
    ahb_xfer(pmc_addr(offset), 1'b1, d, rdata, re, r, lat);
    check_resp({tname, " write hresp"}, apb_sub_pkg::HRESP_OKAY, r);
  endtask

  task automatic reg_read(input string tname, input logic [15:0] offset,
                          output logic [31:0] d);
    logic [1:0] re;
    logic [1:0] r;
    int         lat;
    ahb_xfer(pmc_addr(offset), 1'b0, 32'h0, d, re, r, lat);
    check_resp({tname, " read hresp"}, apb_sub_pkg::HRESP_OKAY, r);
    check_count({tname, " read latency"}, 3, lat);   // Slot 6 has no wait states
  endtask

  // --------------------------------------------------
  // Directed tests
  // --------------------------------------------------
  task automatic reset_state();
    check_bit("reset hready", 1'b1, hready);
    check_resp("reset hresp", apb_sub_pkg::HRESP_OKAY, hresp);
    check_sel("reset psel", '0, psel);
    check_bit("reset penable", 1'b0, apb_req.penable);
    check_bit("reset wake", 1'b0, wake);
    check_irq("reset irq", '0, irq);
  endtask

  task automatic write_slots();
    logic [31:0]            addr;
    logic [31:0]            wdata;
    logic [31:0]            rdata;
    logic [1:0]             re;
    logic [1:0]             r;
    int                     lat;
    int                     base;
    string                  tn;
    apb_sub_pkg::slot_sel_t exp_sel;
    logic [3:0]             exp_strb;
    for (int s = 0; s < apb_sub_pkg::NUM_SLOTS; s++) begin
      if (s == apb_sub_pkg::SLOT_PMC) continue;
      wdata = lcg_next();
      addr  = {apb_sub_pkg::SLOT_REGION, 4'(s), wdata[31:16]};   // Random offset
      wdata = lcg_next();
      base  = apb_cnt;
      tn    = $sformatf("write slot %0d", s);
      ahb_xfer(addr, 1'b1, wdata, rdata, re, r, lat);
      exp_sel    = '0;
      exp_sel[s] = 1'b1;
      exp_strb   = apb_sub_pkg::BYTE_SLOTS[s] ? (4'b0001 << addr[1:0]) : 4'b1111;
      check_count({tn, " apb count"}, base + 1, apb_cnt);
      check_sel({tn, " psel"}, exp_sel, log_sel);
      check_word({tn, " paddr"}, addr, log_req.paddr.raw);
      check_word({tn, " pwdata"}, wdata, log_req.pwdata);
      check_bit({tn, " pwrite"}, 1'b1, log_req.pwrite);
      check_strb({tn, " pstrb"}, exp_strb, log_req.pstrb);
      check_resp({tn, " hresp"}, apb_sub_pkg::HRESP_OKAY, r);
    end
  endtask

  task automatic read_slots();
    logic [31:0] addr;
    logic [31:0] rdata;
    logic [1:0]  re;
    logic [1:0]  r;
    int          lat;
    string       tn;
    for (int s = 0; s < apb_sub_pkg::NUM_SLOTS; s++) begin
      if (s == apb_sub_pkg::SLOT_PMC) continue;
      addr = lcg_next();
      addr = {apb_sub_pkg::SLOT_REGION, 4'(s), addr[15:0]};
      tn   = $sformatf("read slot %0d", s);
      ahb_xfer(addr, 1'b0, 32'h0, rdata, re, r, lat);
      // Setup, s+1 access cycles, completion
      check_count({tn, " latency"}, s + 3, lat);
      check_word({tn, " hrdata"}, {8'(s), 24'h0} ^ {16'h0, addr[15:0]}, rdata);
      check_resp({tn, " early hresp"}, apb_sub_pkg::HRESP_OKAY, re);
      check_resp({tn, " hresp"}, apb_sub_pkg::HRESP_OKAY, r);
      check_bit({tn, " pwrite"}, 1'b0, log_req.pwrite);
    end
  endtask

  task automatic unmapped_access();
    logic [31:0] addrs [3];
    logic [31:0] rdata;
    logic [1:0]  re;
    logic [1:0]  r;
    int          lat;
    int          base;
    string       tn;
    addrs[0] = 32'h0089_0010;                 // Slot field 9
    addrs[1] = 32'h008F_1234;                 // Slot field 15
    addrs[2] = 32'h0010_0000;                 // Outside the region
    for (int i = 0; i < 3; i++) begin
      base = psel_cnt;
      tn   = $sformatf("unmapped %h", addrs[i]);
      ahb_xfer(addrs[i], i[0], lcg_next(), rdata, re, r, lat);
      check_resp({tn, " first hresp"}, apb_sub_pkg::HRESP_ERROR, re);
      check_count({tn, " error cycles"}, 2, lat);
      check_resp({tn, " last hresp"}, apb_sub_pkg::HRESP_ERROR, r);
      check_count({tn, " psel cycles"}, base, psel_cnt);
    end
  endtask

  task automatic pmc_registers();
    logic [31:0]           d;
    logic [31:0]           rnd;
    apb_sub_pkg::irq_src_t src;
    rnd = lcg_next();
    src = apb_sub_pkg::irq_src_t'(rnd[12:0]);
    reg_write("mask", apb_sub_pkg::REG_MASK, irq_word(src));
    reg_read("mask", apb_sub_pkg::REG_MASK, d);
    check_word("mask readback", irq_word(src), d);
    reg_write("mask clear", apb_sub_pkg::REG_MASK, 32'h0);
    reg_write("ctrl", apb_sub_pkg::REG_CTRL, 32'h1);
    reg_read("ctrl", apb_sub_pkg::REG_CTRL, d);
    check_word("ctrl readback set", 32'h1, d);
    reg_write("ctrl", apb_sub_pkg::REG_CTRL, 32'h0);
    reg_read("ctrl", apb_sub_pkg::REG_CTRL, d);
    check_word("ctrl readback clear", 32'h0, d);
    // STATUS follows the sources one cycle late
    rnd = lcg_next();
    src = apb_sub_pkg::irq_src_t'(rnd[20:8]);
    @(posedge hclk);
    irq_src <= src;
    wait_cycles(2);
    reg_read("status", apb_sub_pkg::REG_STATUS, d);
    check_word("status readback", irq_word(src), d);
    @(posedge hclk);
    irq_src <= '0;
    wait_cycles(2);
  endtask

  // Drive one source pattern, then compare o_irq and the wake pulse count
  task automatic pulse_source(input string tname, input apb_sub_pkg::irq_src_t src,
                              input apb_sub_pkg::irq_src_t exp_irq, input int exp_wakes);
    int base;
    base = wake_cnt;
    @(posedge hclk);
    irq_src <= src;
    wait_cycles(6);
    check_irq({tname, " irq"}, exp_irq, irq);
    check_count({tname, " wake pulses"}, base + exp_wakes, wake_cnt);
    @(posedge hclk);
    irq_src <= '0;
    wait_cycles(3);
  endtask

  task automatic irq_masking();
    apb_sub_pkg::irq_src_t src;
    apb_sub_pkg::irq_src_t exp;
    src = '0;
    src.uart0 = 1'b1;
    reg_write("mask uart0", apb_sub_pkg::REG_MASK, irq_word(src));
    exp = src;
    pulse_source("unmasked uart0", src, exp, 1);
    src = '0;
    src.spi = 1'b1;
    pulse_source("masked spi", src, '0, 0);
    // Hibernate, GPIO only wakes
    reg_write("mask all", apb_sub_pkg::REG_MASK, irq_word('1));
    reg_write("hibernate", apb_sub_pkg::REG_CTRL, 32'h1);
    src = '0;
    src.uart0 = 1'b1;
    pulse_source("hibernate uart0", src, src, 0);
    src = '0;
    src.gpio = 1'b1;
    pulse_source("hibernate gpio", src, src, 1);
    reg_write("wake up", apb_sub_pkg::REG_CTRL, 32'h0);
    reg_write("mask clear", apb_sub_pkg::REG_MASK, 32'h0);
  endtask

  // --------------------------------------------------
  // Main sequence
  // --------------------------------------------------
  initial begin
    arst_n    = 1'b0;
    hsel      = 1'b0;
    haddr     = '0;
    htrans    = 2'b00;
    hwrite    = 1'b0;
    hwdata    = '0;
    hready_in = 1'b1;
    irq_src   = '0;
    lcg_state = 32'hb224_3143;
    repeat (5) @(posedge hclk);
    arst_n <= 1'b1;
    @(negedge hclk);
    reset_state();
    write_slots();
    read_slots();
    unmapped_access();
    pmc_registers();
    irq_masking();
    wait_cycles(4);
    $display("Summary: %0d checks, %0d check errors, %0d assertion errors",
             checks, errors, apb_sub_i.u_bridge.u_chk.err_count);
    if ((errors == 0) && (apb_sub_i.u_bridge.u_chk.err_count == 0)) begin
      $display("PASS: all tests");
    end else begin
      $display("FAIL: see errors above");
    end
    $finish;
  end

endmodule

`default_nettype wire

// File: project.f
design/apb_sub_pkg.sv
design/ahb_apb_bridge.sv
design/apb_slot_decoder.sv
design/irq_wake_ctrl.sv
design/apb_sub_top.sv
dv/apb_sub_chk.sv
dv/apb_sub_tb.sv
